// ==== sources.f ====
hw/ps2_pkg.sv
hw/ps2_byte_if.sv
hw/ps2_rx.sv
hw/ps2_tx.sv
hw/mouse_packet_asm.sv
hw/mouse_tracker.sv
hw/ps2_mouse_host.sv
verif/tb_ps2_mouse_host.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the PS/2 mouse host testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ps2_mouse_host \
  -f sources.f \
  --Mdir build/obj -o sim_tb

./build/obj/sim_tb | tee build/sim.log

if grep -qx "TEST PASS" build/sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// ==== verif/tb_ps2_mouse_host.sv ====
/*
 * Directed testbench for the PS/2 mouse host.
 * A behavioral mouse sits on the far side of the open-drain bus. It sends
 * frames and answers host commands. Six tests cover byte receive, receive
 * errors, cursor tracking, sync loss, command send and command failure.
 */
`timescale 1ns/1ps

module tb_ps2_mouse_host;

  import ps2_pkg::*;

  localparam int FILT    = 2;     // short filter and timeouts keep runs quick
  localparam int INH_CYC = 40;
  localparam int TX_TMO  = 400;

  localparam int EV_RX   = 0;     // event counter slots
  localparam int EV_ERR  = 1;
  localparam int EV_PKT  = 2;
  localparam int EV_SYNC = 3;
  localparam int EV_DONE = 4;
  localparam int EV_CERR = 5;

  logic       clk;
  logic       rst_n;
  logic [7:0] cmd_data;
  logic       cmd_send;
  logic       inhibit;
  logic       dev_clk;            // mouse side drive, 0 pulls low
  logic       dev_dat;
  logic       ps2_clk;
  logic       ps2_dat;
  logic       ps2_clk_low;
  logic       ps2_dat_low;
  logic [7:0] rx_data;
  logic       rx_strobe;
  logic       rx_error;
  logic       cmd_done;
  logic       cmd_error;
  logic       packet_strobe;
  logic       sync_error;
  pos_t       pos_x;
  pos_t       pos_y;
  logic [2:0] buttons;

  int         ev_cnt [6];
  int         base [6];
  int         inh_viol;           // cycles with inhibit high but clock released
  int         errors;
  int         passed;
  int         exp_x;              // reference cursor
  int         exp_y;
  logic [2:0] exp_btn;

  // wired-AND bus, either side can pull a line low
  assign ps2_clk = dev_clk & ~ps2_clk_low;
  assign ps2_dat = dev_dat & ~ps2_dat_low;

  ps2_mouse_host #(
    .FILTER_LEN     (FILT),
    .INHIBIT_CYCLES (INH_CYC),
    .TX_TIMEOUT     (TX_TMO)
  ) dut0 (
    .clk (clk), .rst_n (rst_n), .cmd_data (cmd_data), .cmd_send (cmd_send),
    .inhibit (inhibit), .ps2_clk (ps2_clk), .ps2_dat (ps2_dat),
    .ps2_clk_low (ps2_clk_low), .ps2_dat_low (ps2_dat_low),
    .rx_data (rx_data), .rx_strobe (rx_strobe), .rx_error (rx_error),
    .cmd_done (cmd_done), .cmd_error (cmd_error), .packet_strobe (packet_strobe),
    .sync_error (sync_error), .pos_x (pos_x), .pos_y (pos_y), .buttons (buttons)
  );

  always #5 clk = ~clk;

  // strobe counters, tests look at them on the falling edge
  always @(posedge clk) begin
    if (rx_strobe === 1'b1) ev_cnt[EV_RX]++;
    if (rx_error === 1'b1) ev_cnt[EV_ERR]++;
    if (packet_strobe === 1'b1) ev_cnt[EV_PKT]++;
    if (sync_error === 1'b1) ev_cnt[EV_SYNC]++;
    if (cmd_done === 1'b1) ev_cnt[EV_DONE]++;
    if (cmd_error === 1'b1) ev_cnt[EV_CERR]++;
    if (inhibit === 1'b1 && ps2_clk_low !== 1'b1) inh_viol++;
  end

  // --------------------------------------------------
  // reporting and waits
  // --------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
    errors++;
  endtask

  task automatic report_fail(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      passed++;
      $display("test %-18s ok", name);
    end else begin
      $display("test %-18s failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic take_base();
    @(negedge clk);
    base = ev_cnt;
  endtask

  function automatic int seen(input int sel);
    return ev_cnt[sel] - base[sel];
  endfunction

  task automatic wait_for(input int sel, input int n, input int limit, input string what);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (seen(sel) < n && t < limit);
    if (seen(sel) < n) report_fail($sformatf("timeout after %0d cycles waiting for %s",
                                             limit, what));
  endtask

  task automatic wait_clk(input logic val, input int limit, input string what,
                          output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ps2_clk !== val && n < limit);
    if (ps2_clk !== val) report_fail({"timeout waiting for ", what});
  endtask

  // --------------------------------------------------
  // mouse model and host stimulus
  // --------------------------------------------------
  task automatic reset_dut();
    @(posedge clk);
    rst_n    <= 1'b0;
    cmd_send <= 1'b0;
    inhibit  <= 1'b0;
    dev_clk  <= 1'b1;
    dev_dat  <= 1'b1;
    repeat (16) @(posedge clk);
    rst_n   <= 1'b1;
    exp_x   = 0;
    exp_y   = 0;
    exp_btn = 3'b000;
    repeat (4) @(posedge clk);
  endtask

  // device clock period 20 cycles, data set up 5 cycles before the fall
  task automatic send_byte(input logic [7:0] b, input bit bad_par, input bit bad_stop);
    logic [10:0] frame;
    frame = {~bad_stop, (~^b) ^ bad_par, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      dev_dat <= frame[i];
      repeat (5) @(posedge clk);
      dev_clk <= 1'b0;
      repeat (10) @(posedge clk);
      dev_clk <= 1'b1;
      repeat (4) @(posedge clk);
    end
    @(posedge clk);
    dev_dat <= 1'b1;
    repeat (20) @(posedge clk);   // idle gap between frames
  endtask

  task automatic recv_cmd(input bit no_ack, output logic [7:0] got, output bit par_ok);
    logic [9:0] bits;
    int         n;
    wait_clk(1'b0, 20, "host clock inhibit", n);
    wait_clk(1'b1, INH_CYC + 20, "host clock release", n);
    if (n < INH_CYC - 2) report_fail("host held the clock low for too short a time");
    if (ps2_dat !== 1'b0) report_fail("no start bit when the host released the clock");
    repeat (10) @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      dev_clk <= 1'b0;
      repeat (9) @(posedge clk);
      @(negedge clk);
      bits[i] = ps2_dat;          // read just before the rising edge
      @(posedge clk);
      dev_clk <= 1'b1;
      repeat (8) @(posedge clk);
    end
    @(posedge clk);
    dev_dat <= no_ack;            // ack is data held low over one clock
    repeat (5) @(posedge clk);
    dev_clk <= 1'b0;
    repeat (10) @(posedge clk);
    dev_clk <= 1'b1;
    repeat (5) @(posedge clk);
    dev_dat <= 1'b1;
    got    = bits[7:0];
    par_ok = (bits[8] == ~^bits[7:0]) && bits[9];
  endtask

  task automatic start_cmd(input logic [7:0] c);
    @(posedge clk);
    cmd_data <= c;
    cmd_send <= 1'b1;
    @(posedge clk);
    cmd_send <= 1'b0;
  endtask

  // --------------------------------------------------
  // reference cursor
  // --------------------------------------------------
  function automatic int delta9(input bit sign, input logic [7:0] mag);
    return sign ? int'(mag) - 256 : int'(mag);
  endfunction

  function automatic int clamp_pos(input int v);
    if (v > int'(POS_MAX)) return int'(POS_MAX);
    if (v < int'(POS_MIN)) return int'(POS_MIN);
    return v;
  endfunction

  task automatic send_packet_checked(input logic [7:0] b0, input logic [7:0] dx,
                                     input logic [7:0] dy);
    take_base();
    send_byte(b0, 1'b0, 1'b0);
    send_byte(dx, 1'b0, 1'b0);
    send_byte(dy, 1'b0, 1'b0);
    wait_for(EV_PKT, 1, 100, "packet_strobe");
    if (seen(EV_PKT) != 1) report_mismatch("packet_strobe count", seen(EV_PKT), 1);
    exp_btn = b0[2:0];
    if (!b0[6]) exp_x = clamp_pos(exp_x + delta9(b0[4], dx));   // overflow holds the axis
    if (!b0[7]) exp_y = clamp_pos(exp_y + delta9(b0[5], dy));
    if (pos_x !== pos_t'(exp_x)) report_mismatch("pos_x", 32'(pos_x), exp_x);
    if (pos_y !== pos_t'(exp_y)) report_mismatch("pos_y", 32'(pos_y), exp_y);
    if (buttons !== exp_btn) report_mismatch("buttons", buttons, exp_btn);
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic test_byte_receive();
    logic [7:0] b;
    reset_dut();
    for (int i = 0; i < 8; i++) begin
      b = 8'($urandom);
      take_base();
      send_byte(b, 1'b0, 1'b0);
      wait_for(EV_RX, 1, 100, "rx_strobe");
      if (seen(EV_RX) != 1) report_mismatch("rx_strobe count", seen(EV_RX), 1);
      if (seen(EV_ERR) != 0) report_mismatch("rx_error count", seen(EV_ERR), 0);
      if (rx_data !== b) report_mismatch("rx_data", rx_data, b);
    end
  endtask

  task automatic test_frame_errors();
    reset_dut();
    take_base();
    send_byte(8'h08, 1'b0, 1'b0);   // byte zero and one, packet left open
    send_byte(8'h44, 1'b0, 1'b0);
    send_byte(8'h5a, 1'b1, 1'b0);   // parity flipped
    wait_for(EV_ERR, 1, 100, "rx_error on bad parity");
    send_byte(8'h33, 1'b0, 1'b1);   // stop bit low
    wait_for(EV_ERR, 2, 100, "rx_error on bad stop bit");
    if (seen(EV_RX) != 2) report_mismatch("rx_strobe count", seen(EV_RX), 2);
    if (seen(EV_ERR) != 2) report_mismatch("rx_error count", seen(EV_ERR), 2);
    send_packet_checked(8'h09, 8'h10, 8'h20);
  endtask

  task automatic test_packet_tracking();
    logic [7:0] b0;
    logic [7:0] dx;
    logic [7:0] dy;
    reset_dut();
    for (int i = 0; i < 14; i++) begin
      b0 = (8'($urandom) & 8'h37) | 8'h08;   // no overflow, sync bit set
      dx = 8'($urandom);
      dy = 8'($urandom);
      if (i < 12) begin
        b0[4] = 1'b0;                        // drive x into the upper limit
        dx    = dx | 8'hc0;
        b0[5] = 1'b1;                        // and y into the lower one
        dy    = dy & 8'h3f;
      end
      send_packet_checked(b0, dx, dy);
    end
    send_packet_checked(8'h5c, 8'h7f, 8'h05);   // x overflow on a leftward move
    send_packet_checked(8'h99, 8'h02, 8'h80);   // y overflow on an upward move
  endtask

  task automatic test_sync_loss();
    logic [7:0] b;
    reset_dut();
    b = 8'($urandom) & 8'hf7;
    take_base();
    send_byte(b, 1'b0, 1'b0);
    wait_for(EV_SYNC, 1, 100, "sync_error");
    if (seen(EV_PKT) != 0) report_mismatch("packet_strobe count", seen(EV_PKT), 0);
    send_packet_checked(8'h2a, 8'h31, 8'hf0);
  endtask

  task automatic test_command_send();
    logic [7:0] c;
    logic [7:0] got;
    bit         par_ok;
    reset_dut();
    c = 8'($urandom);
    take_base();
    start_cmd(c);
    recv_cmd(1'b0, got, par_ok);
    wait_for(EV_DONE, 1, 200, "cmd_done");
    if (got !== c) report_mismatch("command byte", got, c);
    if (!par_ok) report_fail("host frame has a wrong parity or stop bit");
    if (seen(EV_DONE) != 1) report_mismatch("cmd_done count", seen(EV_DONE), 1);
    if (seen(EV_CERR) != 0) report_mismatch("cmd_error count", seen(EV_CERR), 0);
  endtask

  task automatic test_command_failure();
    logic [7:0] got;
    bit         par_ok;
    reset_dut();
    take_base();
    start_cmd(8'hf4);
    recv_cmd(1'b1, got, par_ok);      // ack withheld
    wait_for(EV_CERR, 1, 200, "cmd_error without ack");
    if (seen(EV_DONE) != 0) report_mismatch("cmd_done count", seen(EV_DONE), 0);
    take_base();
    start_cmd(8'hff);                 // mouse stays silent
    wait_for(EV_CERR, 1, INH_CYC + TX_TMO + 100, "cmd_error on a silent bus");
    if (seen(EV_DONE) != 0) report_mismatch("cmd_done count", seen(EV_DONE), 0);
    take_base();
    inh_viol = 0;
    @(posedge clk);
    inhibit <= 1'b1;
    send_byte(8'h08, 1'b0, 1'b0);
    repeat (20) @(posedge clk);
    @(negedge clk);
    if (inh_viol != 0) report_fail("ps2_clk_low dropped while inhibit was high");
    if (seen(EV_RX) != 0) report_mismatch("rx_strobe count", seen(EV_RX), 0);
    if (seen(EV_ERR) != 0) report_mismatch("rx_error count", seen(EV_ERR), 0);
    @(posedge clk);
    inhibit <= 1'b0;
  endtask

  initial begin
    int e0;
    void'($urandom(32'h38d9));
    clk      = 1'b0;
    rst_n    = 1'b0;
    cmd_data = 8'h00;
    cmd_send = 1'b0;
    inhibit  = 1'b0;
    dev_clk  = 1'b1;                  // bus idles high
    dev_dat  = 1'b1;
    errors   = 0;
    passed   = 0;
    inh_viol = 0;
    foreach (ev_cnt[i]) ev_cnt[i] = 0;
    base = ev_cnt;

    e0 = errors;
    test_byte_receive();
    report_test("byte receive", e0);
    e0 = errors;
    test_frame_errors();
    report_test("frame errors", e0);
    e0 = errors;
    test_packet_tracking();
    report_test("packet tracking", e0);
    e0 = errors;
    test_sync_loss();
    report_test("sync loss", e0);
    e0 = errors;
    test_command_send();
    report_test("command send", e0);
    e0 = errors;
    test_command_failure();
    report_test("command failure", e0);

    $display("%0d of 6 tests passed, %0d errors", passed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/ps2_mouse_host.sv ====
/*
 * PS/2 mouse host controller, top level.
 * Each bus line comes in as a read-back level and goes out as a pull-low
 * enable for an external open-drain pad. Received bytes become packets,
 * packets move the cursor. Commands go out one at a time via cmd_send.
 */
`timescale 1ns/1ps

module ps2_mouse_host #(
  parameter int FILTER_LEN     = ps2_pkg::DEF_FILTER_LEN,
  parameter int INHIBIT_CYCLES = ps2_pkg::DEF_INHIBIT_CYCLES,
  parameter int TX_TIMEOUT     = ps2_pkg::DEF_TX_TIMEOUT
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [7:0]    cmd_data,
  input  logic          cmd_send,
  input  logic          inhibit,        // hold the device off the bus
  input  logic          ps2_clk,        // line levels as seen on the pads
  input  logic          ps2_dat,
  output logic          ps2_clk_low,    // 1 pulls the line low
  output logic          ps2_dat_low,
  output logic [7:0]    rx_data,
  output logic          rx_strobe,
  output logic          rx_error,
  output logic          cmd_done,
  output logic          cmd_error,
  output logic          packet_strobe,
  output logic          sync_error,
  output ps2_pkg::pos_t pos_x,
  output ps2_pkg::pos_t pos_y,
  output logic [2:0]    buttons
);

  import ps2_pkg::*;

  ps2_byte_if rx_byte ();

  mouse_pkt_t pkt;
  logic       clk_fall;
  logic       dat_filt;
  logic       tx_busy;
  logic       tx_clk_low;
  logic       rx_hold;

  assign rx_hold     = tx_busy | inhibit;   // own frame is not received
  assign ps2_clk_low = tx_clk_low | inhibit;
  assign rx_data     = rx_byte.data;
  assign rx_strobe   = rx_byte.valid;
  assign rx_error    = rx_byte.parity_err | rx_byte.frame_err;

  // ------------------------------------------------
  // bus side
  // ------------------------------------------------
  ps2_rx #(
    .FILTER_LEN (FILTER_LEN),
    .TIMEOUT    (TX_TIMEOUT)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .ps2_clk  (ps2_clk),
    .ps2_dat  (ps2_dat),
    .hold     (rx_hold),
    .rx       (rx_byte.src),
    .clk_fall (clk_fall),
    .dat_filt (dat_filt)
  );

  ps2_tx #(
    .INHIBIT_CYCLES (INHIBIT_CYCLES),
    .TIMEOUT        (TX_TIMEOUT)
  ) u_tx (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_data    (cmd_data),
    .cmd_send    (cmd_send),
    .clk_fall    (clk_fall),
    .dat_filt    (dat_filt),
    .ps2_clk_low (tx_clk_low),
    .ps2_dat_low (ps2_dat_low),
    .busy        (tx_busy),
    .cmd_done    (cmd_done),
    .cmd_error   (cmd_error)
  );

  // ------------------------------------------------
  // packet path
  // ------------------------------------------------
  mouse_packet_asm u_asm (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx_byte.dst),
    .pkt        (pkt),
    .pkt_valid  (packet_strobe),
    .sync_error (sync_error)
  );

  mouse_tracker u_track (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt       (pkt),
    .pkt_valid (packet_strobe),
    .pos_x     (pos_x),
    .pos_y     (pos_y),
    .buttons   (buttons)
  );

endmodule

// ==== hw/mouse_tracker.sv ====
/*
 * Cursor tracker.
 * Adds each packet's 9-bit signed deltas to a saturating x/y position and
 * latches the button state. An axis with its overflow flag set keeps its
 * old value. Outputs follow pkt_valid by one cycle.
 */
`timescale 1ns/1ps

module mouse_tracker (
  input  logic                clk,
  input  logic                rst_n,
  input  ps2_pkg::mouse_pkt_t pkt,
  input  logic                pkt_valid,
  output ps2_pkg::pos_t       pos_x,
  output ps2_pkg::pos_t       pos_y,
  output logic [2:0]          buttons
);

  import ps2_pkg::*;

  // position plus delta, clamped to the limits
  function automatic pos_t sat_add(pos_t cur, logic sign, logic [7:0] mag);
    logic signed [12:0] sum;
    sum = 13'(cur) + 13'($signed({sign, mag}));   // 9-bit delta, sign extended
    if (sum > POS_MAX)
      return POS_MAX;
    else if (sum < POS_MIN)
      return POS_MIN;
    return sum[11:0];
  endfunction

  pos_t next_x;
  pos_t next_y;

  assign next_x = sat_add(pos_x, pkt.x_sign, pkt.dx);
  assign next_y = sat_add(pos_y, pkt.y_sign, pkt.dy);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos_x   <= '0;
      pos_y   <= '0;
      buttons <= '0;
    end else if (pkt_valid) begin
      buttons <= pkt.buttons;   // always taken
      if (!pkt.x_ovf)
        pos_x <= next_x;
      if (!pkt.y_ovf)
        pos_y <= next_y;
    end
  end

  // -2048 is reachable by the type but never by the clamp
  a_pos_range: assert property (@(posedge clk) disable iff (!rst_n)
    pos_x >= POS_MIN && pos_x <= POS_MAX && pos_y >= POS_MIN && pos_y <= POS_MAX);

endmodule

// ==== hw/mouse_packet_asm.sv ====
/*
 * Mouse packet assembler.
 * Collects three received bytes into one movement packet. Byte zero must
 * carry the always-one bit 3, otherwise it is dropped with a sync_error
 * strobe. Receive errors restart the packet. pkt_valid pulses one cycle
 * after the third byte.
 */
`timescale 1ns/1ps

module mouse_packet_asm (
  input  logic                clk,
  input  logic                rst_n,
  ps2_byte_if.dst             rx,
  output ps2_pkg::mouse_pkt_t pkt,
  output logic                pkt_valid,
  output logic                sync_error
);

  logic [1:0] idx;    // next byte position
  logic [7:0] b0;     // status byte
  logic [7:0] b1;     // x delta

  // ------------------------------------------------
  // byte counter and packet register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    pkt_valid  <= 1'b0;
    sync_error <= 1'b0;
    if (!rst_n) begin
      idx <= 2'd0;
    end else if (rx.parity_err || rx.frame_err) begin
      idx <= 2'd0;                    // start over from a fresh byte zero
    end else if (rx.valid) begin
      case (idx)
        2'd0: begin
          if (rx.data[3]) begin
            b0  <= rx.data;
            idx <= 2'd1;
          end else begin
            sync_error <= 1'b1;       // out of step, drop it
          end
        end
        2'd1: begin
          b1  <= rx.data;
          idx <= 2'd2;
        end
        default: begin
          pkt.buttons <= b0[2:0];
          pkt.x_sign  <= b0[4];
          pkt.y_sign  <= b0[5];
          pkt.x_ovf   <= b0[6];
          pkt.y_ovf   <= b0[7];
          pkt.dx      <= b1;
          pkt.dy      <= rx.data;     // third byte straight in
          pkt_valid   <= 1'b1;
          idx         <= 2'd0;
        end
      endcase
    end
  end

  a_pkt_after_byte: assert property (@(posedge clk) disable iff (!rst_n)
    pkt_valid |-> $past(rx.valid));

endmodule

// ==== hw/ps2_tx.sv ====
/*
 * PS/2 host-to-device command transmitter.
 * A cmd_send strobe starts one transfer: clock inhibit, request to send,
 * eight data bits and odd parity clocked by the device, stop bit and the
 * device acknowledge. Ends in one cmd_done or one cmd_error strobe.
 * Uses the filtered line view from the receiver.
 */
`timescale 1ns/1ps

module ps2_tx #(
  parameter int INHIBIT_CYCLES = ps2_pkg::DEF_INHIBIT_CYCLES,
  parameter int TIMEOUT        = ps2_pkg::DEF_TX_TIMEOUT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] cmd_data,
  input  logic       cmd_send,
  input  logic       clk_fall,     // filtered device edge
  input  logic       dat_filt,
  output logic       ps2_clk_low,
  output logic       ps2_dat_low,
  output logic       busy,
  output logic       cmd_done,
  output logic       cmd_error
);

  localparam int CNT_MAX = (TIMEOUT > INHIBIT_CYCLES) ? TIMEOUT : INHIBIT_CYCLES;
  localparam int CW      = $clog2(CNT_MAX + 1);

  typedef enum logic [2:0] {
    S_IDLE, S_INHIBIT, S_REQUEST, S_SHIFT, S_PARITY, S_STOP, S_ACK, S_DONE
  } state_t;

  state_t        state;
  logic [7:0]    sh;        // command bits still to go
  logic          par;
  logic [3:0]    bit_cnt;
  logic [CW-1:0] cnt;       // inhibit length, then edge gap
  logic          dat_drv;   // 1 pulls data low
  logic          waiting;
  logic          timed_out;

  assign waiting     = state inside {S_REQUEST, S_SHIFT, S_PARITY, S_STOP, S_ACK};
  assign timed_out   = (cnt == CW'(TIMEOUT - 1));
  assign ps2_clk_low = (state == S_INHIBIT);
  assign ps2_dat_low = dat_drv;
  assign busy        = (state != S_IDLE);
  assign cmd_done    = (state == S_DONE);

  always_ff @(posedge clk) begin
    cmd_error <= 1'b0;
    if (!rst_n) begin
      state   <= S_IDLE;
      dat_drv <= 1'b0;
      bit_cnt <= '0;
      cnt     <= '0;
    end else begin
      // own clock pull shows up as an edge during inhibit, ignore it there
      if (state == S_IDLE || (clk_fall && state != S_INHIBIT))
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;

      case (state)
        S_IDLE: if (cmd_send) begin
          sh    <= cmd_data;
          par   <= ~^cmd_data;          // odd parity
          state <= S_INHIBIT;
        end
        S_INHIBIT: begin
          if (cnt == CW'(INHIBIT_CYCLES - 2))
            dat_drv <= 1'b1;            // start bit, one cycle before release
          if (cnt == CW'(INHIBIT_CYCLES - 1)) begin
            cnt   <= '0;
            state <= S_REQUEST;         // clock released here
          end
        end
        S_REQUEST, S_SHIFT: if (clk_fall) begin
          if (bit_cnt == 4'd8) begin
            dat_drv <= ~par;
            state   <= S_PARITY;
          end else begin
            dat_drv <= ~sh[0];          // LSB first
            sh      <= sh >> 1;
            bit_cnt <= bit_cnt + 4'd1;
            state   <= S_SHIFT;
          end
        end
        S_PARITY: if (clk_fall) begin
          dat_drv <= 1'b0;              // stop bit, line released
          state   <= S_STOP;
        end
        S_STOP: if (clk_fall) begin
          if (!dat_filt) begin
            state <= S_ACK;             // device pulled data low
          end else begin
            cmd_error <= 1'b1;          // no ack
            state     <= S_IDLE;
          end
        end
        S_ACK: if (dat_filt)
          state <= S_DONE;              // device let go of data
        default: state <= S_IDLE;       // S_DONE, one cycle
      endcase

      if (waiting && timed_out && !clk_fall) begin
        dat_drv   <= 1'b0;
        cmd_error <= 1'b1;
        state     <= S_IDLE;
      end
      if (state == S_IDLE)
        bit_cnt <= '0;
    end
  end

  a_done_xor_err: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_done && cmd_error));

  // clock pull never outlasts the inhibit time
  a_clk_pull_inhibit: assert property (@(posedge clk) disable iff (!rst_n)
    ps2_clk_low |-> cnt < CW'(INHIBIT_CYCLES));

endmodule

// ==== hw/ps2_rx.sv ====
/*
 * PS/2 device-to-host receiver.
 * Synchronizes and glitch-filters the clock and data lines, finds falling
 * clock edges and shifts in an eleven-bit frame. Each frame ends in one
 * strobe on the byte interface. The filtered edge and data level are
 * shared with the command transmitter. hold parks the frame logic.
 */
`timescale 1ns/1ps

module ps2_rx #(
  parameter int FILTER_LEN = ps2_pkg::DEF_FILTER_LEN,
  parameter int TIMEOUT    = ps2_pkg::DEF_TX_TIMEOUT
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    ps2_clk,
  input  logic    ps2_dat,
  input  logic    hold,       // host busy or inhibit
  ps2_byte_if.src rx,
  output logic    clk_fall,   // filtered falling edge, one cycle
  output logic    dat_filt
);

  localparam int TW = $clog2(TIMEOUT + 1);

  // ------------------------------------------------
  // line conditioning, index 0 clock, 1 data
  // ------------------------------------------------
  logic [1:0]            sync_a;
  logic [1:0]            sync_b;
  logic [FILTER_LEN-1:0] hist [2];
  logic [1:0]            filt;
  logic                  clk_prev;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_a   <= 2'b11;   // idle bus is high
      sync_b   <= 2'b11;
      filt     <= 2'b11;
      clk_prev <= 1'b1;
      for (int i = 0; i < 2; i++) begin
        hist[i] <= '1;
      end
    end else begin
      sync_a   <= {ps2_dat, ps2_clk};
      sync_b   <= sync_a;
      clk_prev <= filt[0];
      for (int i = 0; i < 2; i++) begin
        hist[i] <= (hist[i] << 1) | FILTER_LEN'(sync_b[i]);
        if (hist[i] == '1)
          filt[i] <= 1'b1;   // steady high
        else if (hist[i] == '0)
          filt[i] <= 1'b0;   // steady low
      end
    end
  end

  assign clk_fall = clk_prev & ~filt[0];
  assign dat_filt = filt[1];

  // ------------------------------------------------
  // frame deserializer
  // ------------------------------------------------
  logic          in_frame;
  logic [3:0]    bit_cnt;    // bits taken so far
  logic [9:0]    shreg;      // start, data, parity once full
  logic [TW-1:0] idle_cnt;
  logic          frame_ok;
  logic          par_ok;

  assign frame_ok = !shreg[0] && dat_filt;   // start low, stop high on this edge
  assign par_ok   = ^shreg[9:1];             // data plus parity is odd

  always_ff @(posedge clk) begin
    rx.valid      <= 1'b0;
    rx.parity_err <= 1'b0;
    rx.frame_err  <= 1'b0;
    if (!rst_n || hold) begin
      in_frame <= 1'b0;
      bit_cnt  <= '0;
      idle_cnt <= '0;
    end else if (clk_fall) begin
      idle_cnt <= '0;
      if (in_frame && bit_cnt == 4'd10) begin   // stop bit edge
        in_frame      <= 1'b0;
        bit_cnt       <= '0;
        rx.data       <= shreg[8:1];
        rx.frame_err  <= !frame_ok;
        rx.parity_err <= frame_ok && !par_ok;
        rx.valid      <= frame_ok && par_ok;
      end else begin
        in_frame <= 1'b1;
        bit_cnt  <= bit_cnt + 4'd1;
        shreg    <= {dat_filt, shreg[9:1]};     // LSB arrives first
      end
    end else if (in_frame) begin
      if (idle_cnt == TW'(TIMEOUT - 1)) begin   // device went quiet
        in_frame <= 1'b0;
        bit_cnt  <= '0;
        idle_cnt <= '0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

  a_one_status: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({rx.valid, rx.parity_err, rx.frame_err}));

  // strobe registered before hold rose may still land, so look one cycle back
  a_quiet_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    hold && $past(hold) |-> !(rx.valid || rx.parity_err || rx.frame_err));

endmodule

// ==== hw/ps2_byte_if.sv ====
/*
 * One received PS/2 byte and its status strobes.
 * The receiver drives it through src, the packet assembler reads it
 * through dst. Exactly one strobe fires per frame and there is no
 * back-pressure, so the reader takes data on the cycle of valid.
 */
`timescale 1ns/1ps

interface ps2_byte_if;

  logic [7:0] data;         // frame payload, LSB first on the wire
  logic       valid;        // good frame
  logic       parity_err;   // odd parity check failed
  logic       frame_err;    // bad start or stop bit

  modport src (
    output data, valid, parity_err, frame_err
  );

  modport dst (
    input data, valid, parity_err, frame_err
  );

endinterface

// ==== hw/ps2_pkg.sv ====
/*
 * Shared types and constants for the PS/2 mouse host.
 * Holds the decoded packet layout, the cursor coordinate type with its
 * saturation limits, and the default timing values that the top level
 * hands down to the bus receiver and transmitter.
 */
package ps2_pkg;

  // ------------------------------------------------
  // cursor position
  // ------------------------------------------------
  typedef logic signed [11:0] pos_t;

  localparam pos_t POS_MAX = 12'sd2047;   // symmetric limits
  localparam pos_t POS_MIN = -12'sd2047;

  // ------------------------------------------------
  // standard three-byte movement packet, decoded
  // ------------------------------------------------
  typedef struct packed {
    logic [2:0] buttons;   // {middle, right, left}
    logic       x_sign;
    logic       y_sign;
    logic       x_ovf;
    logic       y_ovf;
    logic [7:0] dx;        // low 8 bits of the 9-bit delta
    logic [7:0] dy;
  } mouse_pkt_t;

  // ------------------------------------------------
  // timing defaults, in system clock cycles
  // ------------------------------------------------
  localparam int DEF_FILTER_LEN     = 4;       // samples a line must hold steady
  localparam int DEF_INHIBIT_CYCLES = 1200;    // host clock pull before a command
  localparam int DEF_TX_TIMEOUT     = 20000;   // max gap between device edges

endpackage
